// ==== hw/drawPointPkg.sv ====
// shared widths, register map, display constants and address region enum
// for the draw-point master

package drawPointPkg;

    // host bus words
    typedef logic [15:0] addrT;
    typedef logic [15:0] dataT;

    // pixel side
    typedef logic [11:0] rgbT;        // 4:4:4 colour
    typedef logic [8:0]  posT;        // wide enough for 0..319
    typedef logic [16:0] pixelIndexT; // linear index over the full 320x240 buffer

    // address classes, decided once in the command stage
    typedef enum logic [1:0]
    {
        regionNone    = 2'd0,
        regionVersion = 2'd1,
        regionParam   = 2'd2,
        regionPixel   = 2'd3
    } addrRegionE;

    // version block, read only
    localparam addrT majorVersionAddr = 16'h0000;
    localparam addrT minorVersionAddr = 16'h0001;
    localparam addrT revisionAddr     = 16'h0002;
    localparam addrT buildAddr        = 16'h0003;

    // parameter block
    localparam addrT configAddr       = 16'h0004; // bit 0 picks buffer half
    localparam addrT refreshRateAddr  = 16'h0005;
    localparam addrT hResAddr         = 16'h0006;
    localparam addrT vResAddr         = 16'h0007;
    localparam addrT colorLenAddr     = 16'h0008;
    localparam addrT reservedAddr     = 16'h0009; // reads as zero

    // pixel window, runs to the top of the address space
    localparam addrT pixelBaseAddr    = 16'h6A00;

    // display geometry and timing
    localparam dataT hRes             = 16'd320;   // px
    localparam dataT vRes             = 16'd240;   // px
    localparam dataT refreshRate      = 16'd60000; // mHz
    localparam dataT colorLen         = 16'd12;    // bits per pixel

    // 320 * 240 / 2, start of the bottom half
    localparam pixelIndexT halfBufferOffset = 17'd38400;

    localparam dataT configResetValue = 16'h0000;

endpackage : drawPointPkg

// ==== hw/cmdDecode.sv ====
// command stage of the draw-point master
// registers the host command and classifies its address region

`timescale 1ns/1ps

module cmdDecode
(
    input  logic                      ul1SysClock,
    input  logic                      reset,

    // host side
    input  drawPointPkg::addrT        cmdAddress,
    input  logic                      cmdRead,
    input  logic                      cmdWrite,
    input  drawPointPkg::dataT        cmdWriteData,

    // decoded command, one cycle later
    output drawPointPkg::addrRegionE  decRegion,
    output drawPointPkg::addrT        decAddress,
    output logic                      decRead,
    output logic                      decWrite,
    output drawPointPkg::dataT        decData
);

    drawPointPkg::addrRegionE regionNext;
    drawPointPkg::addrT       addressNext;

    // address range compare, the only one in the design
    always_comb
    begin
        addressNext = cmdAddress;
        if (cmdAddress >= drawPointPkg::pixelBaseAddr)
        begin
            regionNext  = drawPointPkg::regionPixel;
            addressNext = cmdAddress - drawPointPkg::pixelBaseAddr; // window relative
        end
        else if (cmdAddress <= drawPointPkg::buildAddr)
        begin
            regionNext = drawPointPkg::regionVersion;
        end
        else if (cmdAddress <= drawPointPkg::reservedAddr)
        begin
            regionNext = drawPointPkg::regionParam; // 4..9
        end
        else
        begin
            regionNext = drawPointPkg::regionNone; // gap below the pixel window
        end
    end

    // strobes and region
    always_ff @(posedge ul1SysClock)
    begin
        if (reset)
        begin
            decRead   <= 1'b0;
            decWrite  <= 1'b0;
            decRegion <= drawPointPkg::regionNone;
        end
        else
        begin
            decRead   <= cmdRead;
            decWrite  <= cmdWrite;
            decRegion <= regionNext;
        end
    end

    // payload, qualified by the strobes downstream
    always_ff @(posedge ul1SysClock)
    begin
        decAddress <= addressNext;
        decData    <= cmdWriteData;
    end

endmodule : cmdDecode

// ==== hw/regFile.sv ====
// register stage of the draw-point master
// config register, read mux and read data-valid

`timescale 1ns/1ps

module regFile
#(
    parameter logic [7:0] majorVersion = 8'hFF,
    parameter logic [7:0] minorVersion = 8'h00,
    parameter logic [7:0] revision     = 8'h00,
    parameter logic [7:0] build        = 8'h01
)
(
    input  logic                      ul1SysClock,
    input  logic                      reset,

    // decoded command
    input  drawPointPkg::addrRegionE  decRegion,
    input  drawPointPkg::addrT        decAddress,
    input  logic                      decRead,
    input  logic                      decWrite,
    input  drawPointPkg::dataT        decData,

    // host read return
    output drawPointPkg::dataT        cmdReadData,
    output logic                      cmdReadDataValid,

    // to the pixel path
    output logic                      bufferSelect
);

    drawPointPkg::dataT configReg;
    drawPointPkg::dataT readValue;
    logic               readMapped;

    // read mux over both register blocks
    always_comb
    begin
        readValue  = '0;
        readMapped = 1'b0;
        case (decRegion)
            drawPointPkg::regionVersion:
            begin
                readMapped = 1'b1;
                case (decAddress)
                    drawPointPkg::majorVersionAddr: readValue = {8'h00, majorVersion};
                    drawPointPkg::minorVersionAddr: readValue = {8'h00, minorVersion};
                    drawPointPkg::revisionAddr:     readValue = {8'h00, revision};
                    default:                        readValue = {8'h00, build};
                endcase
            end
            drawPointPkg::regionParam:
            begin
                readMapped = 1'b1;
                case (decAddress)
                    drawPointPkg::configAddr:      readValue = configReg;
                    drawPointPkg::refreshRateAddr: readValue = drawPointPkg::refreshRate;
                    drawPointPkg::hResAddr:        readValue = drawPointPkg::hRes;
                    drawPointPkg::vResAddr:        readValue = drawPointPkg::vRes;
                    drawPointPkg::colorLenAddr:    readValue = drawPointPkg::colorLen;
                    default:                       readValue = '0; // reserved
                endcase
            end
            default:
            begin
                readMapped = 1'b0; // unmapped, no response
            end
        endcase
    end

    // second read stage, one result per cycle
    always_ff @(posedge ul1SysClock)
    begin
        if (reset)
        begin
            cmdReadData      <= '0;
            cmdReadDataValid <= 1'b0;
        end
        else
        begin
            cmdReadDataValid <= decRead & readMapped;
            cmdReadData      <= (decRead & readMapped) ? readValue : '0;
        end
    end

    // only the config register is writable
    always_ff @(posedge ul1SysClock)
    begin
        if (reset)
        begin
            configReg <= drawPointPkg::configResetValue;
        end
        else if (decWrite && decRegion == drawPointPkg::regionParam
                 && decAddress == drawPointPkg::configAddr)
        begin
            configReg <= decData;
        end
    end

    assign bufferSelect = configReg[0]; // 1 = bottom half

endmodule : regFile

// ==== hw/pixelMapper.sv ====
// pixel stages of the draw-point master
// half-buffer offset, index to X/Y split and draw-point output registers

`timescale 1ns/1ps

module pixelMapper
(
    input  logic                      ul1SysClock,
    input  logic                      reset,

    // decoded command
    input  drawPointPkg::addrRegionE  decRegion,
    input  drawPointPkg::addrT        decAddress,
    input  logic                      decWrite,
    input  drawPointPkg::dataT        decData,
    input  logic                      bufferSelect,

    // draw-point receiver, no back-pressure
    output logic                      dpUpdate,
    output drawPointPkg::posT         dpPosX,
    output drawPointPkg::posT         dpPosY,
    output drawPointPkg::rgbT         dpRgb
);

    drawPointPkg::pixelIndexT pixelIndex;
    drawPointPkg::pixelIndexT indexOffset;
    drawPointPkg::pixelIndexT posXFull;
    drawPointPkg::pixelIndexT posYFull;
    drawPointPkg::rgbT        rgbStage;
    logic                     pixelValid;
    logic                     pixelWrite;

    assign pixelWrite  = decWrite && (decRegion == drawPointPkg::regionPixel);
    assign indexOffset = bufferSelect ? drawPointPkg::halfBufferOffset : '0;

    // first stage
    always_ff @(posedge ul1SysClock)
    begin
        if (reset)
        begin
            pixelValid <= 1'b0;
        end
        else
        begin
            pixelValid <= pixelWrite;
        end
    end

    always_ff @(posedge ul1SysClock)
    begin
        if (pixelWrite)
        begin
            pixelIndex <= {1'b0, decAddress} + indexOffset; // window offset is < 38400
            rgbStage   <= decData[11:0];
        end
    end

    // constant divisor, synthesis maps this to fixed logic
    assign posXFull = pixelIndex % drawPointPkg::pixelIndexT'(drawPointPkg::hRes);
    assign posYFull = pixelIndex / drawPointPkg::pixelIndexT'(drawPointPkg::hRes);

    // second stage, outputs hold their last pixel between strobes
    always_ff @(posedge ul1SysClock)
    begin
        if (reset)
        begin
            dpUpdate <= 1'b0;
            dpPosX   <= '0;
            dpPosY   <= '0;
            dpRgb    <= '0;
        end
        else
        begin
            dpUpdate <= pixelValid;
            if (pixelValid)
            begin
                dpPosX <= drawPointPkg::posT'(posXFull); // < 320
                dpPosY <= drawPointPkg::posT'(posYFull); // < 240
                dpRgb  <= rgbStage;
            end
        end
    end

endmodule : pixelMapper

// ==== hw/drawPointMaster.sv ====
// draw-point master top level
// command decode, register file and pixel mapper

`timescale 1ns/1ps

module drawPointMaster
#(
    parameter logic [7:0] majorVersion = 8'hFF,
    parameter logic [7:0] minorVersion = 8'h00,
    parameter logic [7:0] revision     = 8'h00,
    parameter logic [7:0] build        = 8'h01
)
(
    input  logic                ul1SysClock,
    input  logic                reset,

    // host port, always ready
    input  drawPointPkg::addrT  cmdAddress,
    input  logic                cmdRead,
    input  logic                cmdWrite,
    input  drawPointPkg::dataT  cmdWriteData,
    output drawPointPkg::dataT  cmdReadData,
    output logic                cmdReadDataValid,

    // draw-point output
    output logic                dpUpdate,
    output drawPointPkg::posT   dpPosX,
    output drawPointPkg::posT   dpPosY,
    output drawPointPkg::rgbT   dpRgb
);

    drawPointPkg::addrRegionE decRegion;
    drawPointPkg::addrT       decAddress;
    logic                     decRead;
    logic                     decWrite;
    drawPointPkg::dataT       decData;
    logic                     bufferSelect;

    cmdDecode cmdDecodeInst
    (
        .ul1SysClock  (ul1SysClock),
        .reset        (reset),
        .cmdAddress   (cmdAddress),
        .cmdRead      (cmdRead),
        .cmdWrite     (cmdWrite),
        .cmdWriteData (cmdWriteData),
        .decRegion    (decRegion),
        .decAddress   (decAddress),
        .decRead      (decRead),
        .decWrite     (decWrite),
        .decData      (decData)
    );

    regFile
    #(
        .majorVersion (majorVersion),
        .minorVersion (minorVersion),
        .revision     (revision),
        .build        (build)
    )
    regFileInst
    (
        .ul1SysClock      (ul1SysClock),
        .reset            (reset),
        .decRegion        (decRegion),
        .decAddress       (decAddress),
        .decRead          (decRead),
        .decWrite         (decWrite),
        .decData          (decData),
        .cmdReadData      (cmdReadData),
        .cmdReadDataValid (cmdReadDataValid),
        .bufferSelect     (bufferSelect)
    );

    pixelMapper pixelMapperInst
    (
        .ul1SysClock  (ul1SysClock),
        .reset        (reset),
        .decRegion    (decRegion),
        .decAddress   (decAddress),
        .decWrite     (decWrite),
        .decData      (decData),
        .bufferSelect (bufferSelect),
        .dpUpdate     (dpUpdate),
        .dpPosX       (dpPosX),
        .dpPosY       (dpPosY),
        .dpRgb        (dpRgb)
    );

endmodule : drawPointMaster

// ==== tests/drawPointMasterTb.sv ====
// testbench for the draw-point master
// directed and random host traffic, reference model, output checker and watchdog

`timescale 1ns/1ps

module drawPointMasterTb;

    localparam int clockPeriod = 10;
    localparam int directedCommands = 60;
    localparam int randomCommands = 300;
    localparam int watchdogCycles = (directedCommands + randomCommands) * 10 + 100;
    localparam logic [7:0] majorVersion = 8'hFF;
    localparam logic [7:0] minorVersion = 8'h00;
    localparam logic [7:0] revision = 8'h00;
    localparam logic [7:0] build = 8'h01;

    logic        ul1SysClock;
    logic        reset;
    logic [15:0] cmdAddress;
    logic        cmdRead;
    logic        cmdWrite;
    logic [15:0] cmdWriteData;
    logic [15:0] cmdReadData;
    logic        cmdReadDataValid;
    logic        dpUpdate;
    logic [8:0]  dpPosX;
    logic [8:0]  dpPosY;
    logic [11:0] dpRgb;

    logic [15:0] configMirror;    // tracks writes issued to address 4
    logic [15:0] readQ[$];
    time         readTimeQ[$];
    logic [29:0] pixelQ[$];       // {x, y, rgb}
    time         pixelTimeQ[$];
    int          valueErrors;
    int          otherErrors;

    drawPointMaster
    #(
        .majorVersion (majorVersion),
        .minorVersion (minorVersion),
        .revision     (revision),
        .build        (build)
    )
    dut
    (
        .ul1SysClock      (ul1SysClock),
        .reset            (reset),
        .cmdAddress       (cmdAddress),
        .cmdRead          (cmdRead),
        .cmdWrite         (cmdWrite),
        .cmdWriteData     (cmdWriteData),
        .cmdReadData      (cmdReadData),
        .cmdReadDataValid (cmdReadDataValid),
        .dpUpdate         (dpUpdate),
        .dpPosX           (dpPosX),
        .dpPosY           (dpPosY),
        .dpRgb            (dpRgb)
    );

    initial
    begin
        ul1SysClock = 1'b0;
        forever
        begin
            #(clockPeriod / 2) ul1SysClock = ~ul1SysClock;
        end
    end

    // {readValid, readData, pixelValid, x, y, rgb}
    function automatic logic [47:0] expectedResponse(input logic [15:0] addr,
        input logic [15:0] data, input logic isRead, input logic isWrite,
        input logic [15:0] cfg);
        logic        readValid;
        logic [15:0] readData;
        logic        pixelValid;
        int          index;
        logic [8:0]  x;
        logic [8:0]  y;
        readValid = 1'b0;
        readData = '0;
        pixelValid = 1'b0;
        x = '0;
        y = '0;
        if (isRead && addr <= 16'd9)
        begin
            readValid = 1'b1;
            case (addr)
                16'd0: readData = {8'h00, majorVersion};
                16'd1: readData = {8'h00, minorVersion};
                16'd2: readData = {8'h00, revision};
                16'd3: readData = {8'h00, build};
                16'd4: readData = cfg;
                16'd5: readData = 16'd60000;
                16'd6: readData = 16'd320;
                16'd7: readData = 16'd240;
                16'd8: readData = 16'd12;
                default: readData = 16'd0;   // reserved
            endcase
        end
        if (isWrite && addr >= 16'h6A00)
        begin
            pixelValid = 1'b1;
            index = int'(addr - 16'h6A00) + (cfg[0] ? 38400 : 0);
            x = 9'(index % 320);
            y = 9'(index / 320);
        end
        return {readValid, readData, pixelValid, x, y, data[11:0]};
    endfunction

    task automatic compareValue(input string name, input logic [63:0] expected,
        input logic [63:0] actual);
        if (expected !== actual)
        begin
            valueErrors++;
            $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic issueCommand(input logic [15:0] addr, input logic [15:0] data,
        input logic isRead, input logic isWrite);
        logic [47:0] resp;
        resp = expectedResponse(addr, data, isRead, isWrite, configMirror);
        @(posedge ul1SysClock);
        cmdAddress <= addr;
        cmdWriteData <= data;
        cmdRead <= isRead;
        cmdWrite <= isWrite;
        if (resp[47])
        begin
            readQ.push_back(resp[46:31]);
            readTimeQ.push_back($time + 25);   // valid after two edges, seen at the falling edge
        end
        if (resp[30])
        begin
            pixelQ.push_back(resp[29:0]);
            pixelTimeQ.push_back($time + 35);
        end
        if (isWrite && addr == 16'd4)
            configMirror = data;
    endtask

    task automatic idleCycles(input int n);
        repeat (n)
        begin
            @(posedge ul1SysClock);
            cmdRead <= 1'b0;
            cmdWrite <= 1'b0;
        end
    endtask

    task automatic pixelWrite(input logic [15:0] offset, input logic [15:0] data);
        issueCommand(16'h6A00 + offset, data, 1'b0, 1'b1);
    endtask

    // checker, samples on the falling edge
    initial
    begin
        forever
        begin
            @(negedge ul1SysClock);
            if (!reset)
            begin
                if (cmdReadDataValid)
                begin
                    if (readQ.size() == 0)
                    begin
                        otherErrors++;
                        $display("t=%0t read data valid pulsed with no read outstanding", $time);
                    end
                    else
                    begin
                        compareValue("cmdReadData", readQ.pop_front(), cmdReadData);
                        compareValue("cmdReadDataValid time", readTimeQ.pop_front(), $time);
                    end
                end
                else
                begin
                    compareValue("cmdReadData", 0, cmdReadData); // zero while no result
                end
                if (dpUpdate)
                begin
                    if (pixelQ.size() == 0)
                    begin
                        otherErrors++;
                        $display("t=%0t draw-point update with no pixel write outstanding",
                                 $time);
                    end
                    else
                    begin
                        compareValue("dpPosX", pixelQ[0][29:21], dpPosX);
                        compareValue("dpPosY", pixelQ[0][20:12], dpPosY);
                        compareValue("dpRgb", pixelQ[0][11:0], dpRgb);
                        compareValue("dpUpdate time", pixelTimeQ.pop_front(), $time);
                        void'(pixelQ.pop_front());
                    end
                end
                // anything overdue never arrived
                while (readTimeQ.size() > 0 && readTimeQ[0] < $time)
                begin
                    otherErrors++;
                    $display("t=%0t expected read response did not arrive", $time);
                    void'(readTimeQ.pop_front());
                    void'(readQ.pop_front());
                end
                while (pixelTimeQ.size() > 0 && pixelTimeQ[0] < $time)
                begin
                    otherErrors++;
                    $display("t=%0t expected draw-point update did not arrive", $time);
                    void'(pixelTimeQ.pop_front());
                    void'(pixelQ.pop_front());
                end
            end
        end
    end

    initial
    begin
        #(watchdogCycles * clockPeriod);
        $display("timeout: run did not finish within %0d cycles", watchdogCycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        int kind;
        logic [15:0] addr;
        cmdAddress = '0;
        cmdRead = 1'b0;
        cmdWrite = 1'b0;
        cmdWriteData = '0;
        reset = 1'b1;
        configMirror = 16'h0000;
        valueErrors = 0;
        otherErrors = 0;
        void'($urandom(51465));
        repeat (2) @(posedge ul1SysClock);
        reset <= 1'b0;

        // outputs quiet and zero after reset
        repeat (3)
        begin
            @(negedge ul1SysClock);
            compareValue("cmdReadDataValid", 0, cmdReadDataValid);
            compareValue("dpUpdate", 0, dpUpdate);
            compareValue("cmdReadData", 0, cmdReadData);
            compareValue("dpPosX", 0, dpPosX);
            compareValue("dpPosY", 0, dpPosY);
            compareValue("dpRgb", 0, dpRgb);
        end

        for (int a = 0; a < 10; a++)
        begin
            issueCommand(16'(a), 16'h0000, 1'b1, 1'b0);
            idleCycles(3);
        end
        for (int a = 0; a < 10; a++)
            issueCommand(16'(a), 16'h0000, 1'b1, 1'b0);   // back to back
        issueCommand(16'd10, 16'h0000, 1'b1, 1'b0);
        issueCommand(16'h1234, 16'h0000, 1'b1, 1'b0);
        issueCommand(16'h69FF, 16'h0000, 1'b1, 1'b0);
        idleCycles(4);

        // config readback, then writes that must be ignored
        issueCommand(16'd4, 16'h00A4, 1'b0, 1'b1);
        issueCommand(16'd4, 16'h0000, 1'b1, 1'b0);
        issueCommand(16'd0, 16'hBEEF, 1'b0, 1'b1);
        issueCommand(16'd5, 16'hBEEF, 1'b0, 1'b1);
        issueCommand(16'd6, 16'hBEEF, 1'b0, 1'b1);
        issueCommand(16'd9, 16'hBEEF, 1'b0, 1'b1);
        issueCommand(16'd10, 16'hBEEF, 1'b0, 1'b1);
        issueCommand(16'h69FF, 16'hBEEF, 1'b0, 1'b1);
        for (int a = 0; a < 10; a++)
            issueCommand(16'(a), 16'h0000, 1'b1, 1'b0);
        idleCycles(4);

        // top half, then bottom half, then top again
        pixelWrite(16'd0, 16'hFABC);
        pixelWrite(16'd319, 16'h0123);
        pixelWrite(16'd320, 16'h0FFF);
        pixelWrite(16'd38399, 16'h5A5A);
        issueCommand(16'd4, 16'h0001, 1'b0, 1'b1);
        pixelWrite(16'd0, 16'h0ABC);
        pixelWrite(16'd319, 16'h0321);
        pixelWrite(16'd320, 16'h0F0F);
        pixelWrite(16'd38399, 16'hA5A5);
        issueCommand(16'd4, 16'h0000, 1'b0, 1'b1);
        pixelWrite(16'd0, 16'h0777);
        issueCommand(16'd4, 16'h0000, 1'b1, 1'b0);
        idleCycles(5);

        for (int i = 0; i < randomCommands; i++)
        begin
            kind = $urandom_range(0, 2);
            if (kind == 0)
            begin
                addr = ($urandom % 4 == 0) ? 16'($urandom) : 16'($urandom_range(0, 12));
                issueCommand(addr, 16'h0000, 1'b1, 1'b0);
            end
            else if (kind == 1)
                issueCommand(16'($urandom_range(0, 12)), 16'($urandom), 1'b0, 1'b1);
            else
                pixelWrite(16'($urandom_range(0, 38399)), 16'($urandom));
        end
        idleCycles(10);

        if (readQ.size() != 0 || pixelQ.size() != 0)
        begin
            otherErrors++;
            $display("%0d read and %0d pixel results still expected at end of run",
                     readQ.size(), pixelQ.size());
        end
        $display("errors: %0d value mismatches, %0d other", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule : drawPointMasterTb

// ==== sim.f ====
hw/drawPointPkg.sv
hw/cmdDecode.sv
hw/regFile.sv
hw/pixelMapper.sv
hw/drawPointMaster.sv
tests/drawPointMasterTb.sv

// ==== Bender.yml ====
package:
  name: draw_point_master

sources:
  - hw/drawPointPkg.sv
  - hw/cmdDecode.sv
  - hw/regFile.sv
  - hw/pixelMapper.sv
  - hw/drawPointMaster.sv
  - target: test
    files:
      - tests/drawPointMasterTb.sv
